// File: dv/ll_txrx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ll_txrx_assertions (
  input logic clk_wr,
  input logic arst_n,
  input logic rx_online,
  input logic tx_training,
  input logic tx_online_delay,
  input logic rx_online_delay
);

  // Training and data mode are exclusive
  assert property (@(posedge clk_wr) disable iff (!arst_n)
    !(tx_training && tx_online_delay))
    else $error("tx_training and tx_online_delay high together");

  // Data mode only follows training
  assert property (@(posedge clk_wr) disable iff (!arst_n)
    $rose(tx_online_delay) |-> $past(tx_training))
    else $error("TX_ON entered without passing through TX_TRAIN");

  assert property (@(posedge clk_wr) disable iff (!arst_n)
    !rx_online |=> !rx_online_delay)
    else $error("rx_online_delay still high after rx_online dropped");

endmodule

bind ll_sync_fsm ll_txrx_assertions u_assertions (
  .clk_wr          (clk_wr),
  .arst_n          (arst_n),
  .rx_online       (rx_online),
  .tx_training     (tx_training),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay)
);

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_wr,
  output logic arst_n
);

  // 10 ns period
  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // Reset held for three rising edges
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk_wr);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_ll_txrx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ll_txrx;

  localparam int NUM_LANES   = 4;
  localparam int SESSIONS    = 4;
  localparam int ON_CYCLES   = 200;
  localparam int IDLE_CYCLES = 10;
  localparam int MAX_CYCLES  = SESSIONS * (ON_CYCLES + IDLE_CYCLES + 50) + 60;
  localparam int LW          = link_pkg::LANE_DATA_W;

  // Sequencer positions seen by the model
  localparam int M_OFF   = 0;
  localparam int M_WAIT  = 1;
  localparam int M_TRAIN = 2;
  localparam int M_ON    = 3;

  logic                 clk_wr;
  logic                 arst_n;
  logic                 tx_online;
  logic                 rx_online;
  link_pkg::state_t     dstrm_state;
  link_pkg::protid_t    dstrm_protid;
  link_pkg::payload_t   dstrm_data;
  logic                 dstrm_dvalid;
  link_pkg::crc_t       dstrm_crc;
  logic                 dstrm_crc_valid;
  logic                 dstrm_valid;
  link_pkg::state_t     ustrm_state;
  link_pkg::protid_t    ustrm_protid;
  link_pkg::payload_t   ustrm_data;
  logic                 ustrm_dvalid;
  link_pkg::crc_t       ustrm_crc;
  logic                 ustrm_crc_valid;
  logic                 ustrm_valid;
  link_pkg::lane_t      tx_phy [NUM_LANES];
  link_pkg::debug_cnt_t tx_dbg;
  link_pkg::debug_cnt_t rx_dbg;
  sync_pkg::delay_t     delay_x;
  sync_pkg::delay_t     delay_y;
  sync_pkg::delay_t     delay_z;

  integer               seed;
  int                   errors;
  int                   checks;
  int                   cycles;
  int                   tx_run;
  int                   rx_run;
  int                   m_tx;
  int                   m_rx;
  int                   lane_mode;
  link_pkg::flit_t      lane_flit;
  link_pkg::debug_cnt_t exp_tx_count;
  link_pkg::debug_cnt_t exp_rx_count;

  tb_clk_gen u_clk_gen (
    .clk_wr (clk_wr),
    .arst_n (arst_n)
  );

  // PHY lanes looped back
  ll_txrx_top #(
    .NUM_LANES (NUM_LANES)
  ) uut (
    .clk_wr                     (clk_wr),
    .arst_n                     (arst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy[0]),
    .rx_phy0                    (tx_phy[0]),
    .tx_phy1                    (tx_phy[1]),
    .rx_phy1                    (tx_phy[1]),
    .tx_phy2                    (tx_phy[2]),
    .rx_phy2                    (tx_phy[2]),
    .tx_phy3                    (tx_phy[3]),
    .rx_phy3                    (tx_phy[3]),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_dbg),
    .rx_upstream_debug_status   (rx_dbg),
    .delay_x_value              (delay_x),
    .delay_y_value              (delay_y),
    .delay_z_value              (delay_z)
  );

  ////////////////////////////////////////////////////////////
  // Reference model

  // Field order from the top is state, protid, data, crc, dvalid, crc_valid, valid, pad
  function automatic link_pkg::flit_t pack_flit(input logic [7:0] st, input logic [3:0] pid,
      input logic [63:0] dat, input logic [15:0] crc, input logic dv, input logic cv,
      input logic v);
    return {st, pid, dat, crc, dv, cv, v, 1'b0};
  endfunction

  function automatic link_pkg::lane_t lane_expected(input int mode, input link_pkg::flit_t f,
      input int k);
    if (mode == M_ON) begin
      return {1'b0, 1'b1, f[k*LW +: LW]};
    end else if (mode == M_TRAIN) begin
      return {1'b1, 1'b1, {LW{1'b0}}};
    end
    return '0;
  endfunction

  // Position after an edge from the count of consecutive online edges
  function automatic int tx_position(input int run);
    if (run == 0) begin
      return M_OFF;
    end else if (run - 1 <= int'(delay_y)) begin
      return M_WAIT;
    end else if (run - 1 <= int'(delay_y) + int'(delay_z) + 1) begin
      return M_TRAIN;
    end
    return M_ON;
  endfunction

  function automatic int rx_position(input int run);
    if (run == 0) begin
      return M_OFF;
    end else if (run - 1 <= int'(delay_x)) begin
      return M_WAIT;
    end
    return M_ON;
  endfunction

  task automatic check_and_advance();
    link_pkg::flit_t exp_u;
    link_pkg::flit_t got_u;
    link_pkg::flit_t sent;
    link_pkg::lane_t exp_lane;
    // Upstream shows what the lanes carried before this edge
    exp_u = '0;
    if (lane_mode == M_ON) begin
      exp_u = lane_flit;
      if (m_rx != M_ON) begin
        exp_u[3:1] = 3'b000;
      end
    end
    got_u = pack_flit(ustrm_state, ustrm_protid, ustrm_data, ustrm_crc, ustrm_dvalid,
                      ustrm_crc_valid, ustrm_valid);
    checks++;
    if (got_u !== exp_u) begin
      errors++;
      $display("mismatch at %0t: ustrm flit is %h, expected %h", $time, got_u, exp_u);
    end
    if (exp_u[1]) begin
      exp_rx_count = exp_rx_count + 1'b1;
    end
    sent = pack_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_crc, dstrm_dvalid,
                     dstrm_crc_valid, dstrm_valid);
    for (int k = 0; k < NUM_LANES; k++) begin
      exp_lane = lane_expected(m_tx, sent, k);
      checks++;
      if (tx_phy[k] !== exp_lane) begin
        errors++;
        $display("mismatch at %0t: tx_phy%0d is %h, expected %h", $time, k, tx_phy[k],
                 exp_lane);
      end
    end
    if (m_tx == M_ON && dstrm_valid) begin
      exp_tx_count = exp_tx_count + 1'b1;
    end
    lane_mode = m_tx;
    lane_flit = sent;
    tx_run = tx_online ? tx_run + 1 : 0;
    rx_run = rx_online ? rx_run + 1 : 0;
    m_tx = tx_position(tx_run);
    m_rx = rx_position(rx_run);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic drive_random_fields();
    integer r;
    r = $random(seed);
    dstrm_state     = r[7:0];
    dstrm_protid    = r[11:8];
    dstrm_crc       = r[27:12];
    dstrm_valid     = r[28];
    dstrm_dvalid    = r[29];
    dstrm_crc_valid = r[30];
    dstrm_data      = {$random(seed), $random(seed)};
  endtask

  // Model and check on the edge, then drive 1 ns later
  task automatic step_cycle(input logic next_tx_online, input logic next_rx_online);
    @(posedge clk_wr);
    #1;
    check_and_advance();
    tx_online = next_tx_online;
    rx_online = next_rx_online;
    drive_random_fields();
  endtask

  task automatic run_session(input int num);
    integer r;
    r = $random(seed);
    delay_x = {12'h000, r[3:0]};
    delay_y = {12'h000, r[7:4]};
    delay_z = {12'h000, r[11:8]};
    $display("session %0d: x=%0d y=%0d z=%0d", num, delay_x, delay_y, delay_z);
    for (int i = 0; i < ON_CYCLES; i++) begin
      step_cycle(1'b1, 1'b1);
    end
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      step_cycle(1'b0, 1'b0);
    end
    checks += 2;
    if (tx_dbg !== exp_tx_count) begin
      errors++;
      $display("mismatch at %0t: tx debug count is %0d, expected %0d", $time, tx_dbg,
               exp_tx_count);
    end
    if (rx_dbg !== exp_rx_count) begin
      errors++;
      $display("mismatch at %0t: rx debug count is %0d, expected %0d", $time, rx_dbg,
               exp_rx_count);
    end
  endtask

  always @(posedge clk_wr) begin
    cycles <= cycles + 1;
  end

  initial begin : watchdog
    wait (cycles >= MAX_CYCLES);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    seed            = 84;
    errors          = 0;
    checks          = 0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = 1'b0;
    dstrm_crc       = '0;
    dstrm_crc_valid = 1'b0;
    dstrm_valid     = 1'b0;
    delay_x         = '0;
    delay_y         = '0;
    delay_z         = '0;
    tx_run          = 0;
    rx_run          = 0;
    m_tx            = M_OFF;
    m_rx            = M_OFF;
    lane_mode       = M_OFF;
    lane_flit       = '0;
    exp_tx_count    = '0;
    exp_rx_count    = '0;
    wait (arst_n === 1'b1);
    repeat (2) step_cycle(1'b0, 1'b0);
    for (int s = 0; s < SESSIONS; s++) begin
      run_session(s);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/link_pkg.sv
`default_nettype none

package link_pkg;

  // Upper link field widths
  localparam int STATE_W   = 8;
  localparam int PROTID_W  = 4;
  localparam int PAYLOAD_W = 64;
  localparam int CRC_W     = 16;
  localparam int FLIT_W    = 96;
  localparam int DEBUG_W   = 32;

  // Lane word is a flit slice with strobe and marker on top
  localparam int LANE_DATA_W  = 24;
  localparam int LANE_STB_BIT = LANE_DATA_W;
  localparam int LANE_MRK_BIT = LANE_DATA_W + 1;

  // Single bit flags sit just above the pad bit
  localparam int FLIT_VALID_BIT     = 1;
  localparam int FLIT_CRC_VALID_BIT = 2;
  localparam int FLIT_DVALID_BIT    = 3;

  typedef logic [STATE_W-1:0]       state_t;
  typedef logic [PROTID_W-1:0]      protid_t;
  typedef logic [PAYLOAD_W-1:0]     payload_t;
  typedef logic [CRC_W-1:0]         crc_t;
  typedef logic [FLIT_W-1:0]        flit_t;
  typedef logic [LANE_MRK_BIT:0]    lane_t;
  typedef logic [DEBUG_W-1:0]       debug_cnt_t;

endpackage

`default_nettype wire

// File: logic/ll_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ll_delay_timer (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             load,
  input  sync_pkg::delay_t load_value,
  output logic             done
);

  sync_pkg::delay_t count;
  logic             active;

  // High in the cycle where the count has reached zero,
  // so it is sampled on the (N+1)th edge after the load
  assign done = active && (count == '0);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      count  <= '0;
      active <= 1'b0;
    end else if (load) begin
      // Reload wins over an expiring count
      count  <= load_value;
      active <= 1'b1;
    end else if (done) begin
      active <= 1'b0;
    end else if (active) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/ll_flit_map.sv
`timescale 1ns/1ps
`default_nettype none

module ll_flit_map (
  input  link_pkg::state_t   dstrm_state,
  input  link_pkg::protid_t  dstrm_protid,
  input  link_pkg::payload_t dstrm_data,
  input  logic               dstrm_dvalid,
  input  link_pkg::crc_t     dstrm_crc,
  input  logic               dstrm_crc_valid,
  input  logic               dstrm_valid,
  output link_pkg::flit_t    tx_flit,
  input  link_pkg::flit_t    rx_flit,
  output link_pkg::state_t   ustrm_state,
  output link_pkg::protid_t  ustrm_protid,
  output link_pkg::payload_t ustrm_data,
  output logic               ustrm_dvalid,
  output link_pkg::crc_t     ustrm_crc,
  output logic               ustrm_crc_valid,
  output logic               ustrm_valid
);

  // Real field bits including the three flags
  localparam int FIELD_W = link_pkg::STATE_W + link_pkg::PROTID_W +
                           link_pkg::PAYLOAD_W + link_pkg::CRC_W + 3;

  // Pad up to a whole number of lane slices
  localparam int SLICES = (FIELD_W + link_pkg::LANE_DATA_W - 1) / link_pkg::LANE_DATA_W;
  localparam int PAD_W  = SLICES * link_pkg::LANE_DATA_W - FIELD_W;

  // Field offsets above the flags
  localparam int CRC_LSB    = link_pkg::FLIT_DVALID_BIT + 1;
  localparam int DATA_LSB   = CRC_LSB + link_pkg::CRC_W;
  localparam int PROTID_LSB = DATA_LSB + link_pkg::PAYLOAD_W;
  localparam int STATE_LSB  = PROTID_LSB + link_pkg::PROTID_W;

  ////////////////////////////////////////////////////////////
  // Pack with state in the top bits

  assign tx_flit = {dstrm_state,
                    dstrm_protid,
                    dstrm_data,
                    dstrm_crc,
                    dstrm_dvalid,
                    dstrm_crc_valid,
                    dstrm_valid,
                    {PAD_W{1'b0}}};

  ////////////////////////////////////////////////////////////
  // Unpack

  assign ustrm_state     = rx_flit[STATE_LSB +: link_pkg::STATE_W];
  assign ustrm_protid    = rx_flit[PROTID_LSB +: link_pkg::PROTID_W];
  assign ustrm_data      = rx_flit[DATA_LSB +: link_pkg::PAYLOAD_W];
  assign ustrm_crc       = rx_flit[CRC_LSB +: link_pkg::CRC_W];
  assign ustrm_dvalid    = rx_flit[link_pkg::FLIT_DVALID_BIT];
  assign ustrm_crc_valid = rx_flit[link_pkg::FLIT_CRC_VALID_BIT];
  assign ustrm_valid     = rx_flit[link_pkg::FLIT_VALID_BIT];

endmodule

`default_nettype wire

// File: logic/ll_lane_concat.sv
`timescale 1ns/1ps
`default_nettype none

module ll_lane_concat #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  link_pkg::flit_t      tx_flit,
  input  logic                 dstrm_valid,
  input  logic                 tx_online_delay,
  input  logic                 tx_training,
  input  logic                 rx_online_delay,
  output link_pkg::lane_t      tx_lane [NUM_LANES],
  input  link_pkg::lane_t      rx_lane [NUM_LANES],
  output link_pkg::flit_t      rx_flit,
  output link_pkg::debug_cnt_t tx_count,
  output link_pkg::debug_cnt_t rx_count
);

  localparam int LW     = link_pkg::LANE_DATA_W;
  localparam int FLIT_W = $bits(link_pkg::flit_t);
  localparam int WIDE_W = NUM_LANES * LW;

  logic [WIDE_W-1:0] tx_wide;
  logic [WIDE_W-1:0] rx_wide;
  logic [WIDE_W-1:0] rx_wide_q;
  link_pkg::lane_t   tx_lane_d [NUM_LANES];
  logic              rx_qual;
  logic              rx_qual_q;

  ////////////////////////////////////////////////////////////
  // Transmit striping

  // Lanes past the end of the flit carry zero data
  assign tx_wide = WIDE_W'(tx_flit);

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      tx_lane_d[k] = '0;
      if (tx_online_delay) begin
        tx_lane_d[k][link_pkg::LANE_STB_BIT] = 1'b1;
        tx_lane_d[k][LW-1:0]                 = tx_wide[k*LW +: LW];
      end else if (tx_training) begin
        // Training pattern with a marker on every lane
        tx_lane_d[k][link_pkg::LANE_STB_BIT] = 1'b1;
        tx_lane_d[k][link_pkg::LANE_MRK_BIT] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_lane  <= '{default: '0};
      tx_count <= '0;
    end else begin
      tx_lane <= tx_lane_d;
      if (tx_online_delay && dstrm_valid) begin
        tx_count <= tx_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive reassembly

  // Flit is good only if every lane shows strobe without marker
  always_comb begin
    rx_qual = rx_online_delay;
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_wide[k*LW +: LW] = rx_lane[k][LW-1:0];
      rx_qual = rx_qual && rx_lane[k][link_pkg::LANE_STB_BIT] &&
                !rx_lane[k][link_pkg::LANE_MRK_BIT];
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_wide_q <= rx_wide;
  end

  // Counter moves on the same edge that presents the flit
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_qual_q <= 1'b0;
      rx_count  <= '0;
    end else begin
      rx_qual_q <= rx_qual;
      if (rx_qual && rx_wide[link_pkg::FLIT_VALID_BIT]) begin
        rx_count <= rx_count + 1'b1;
      end
    end
  end

  always_comb begin
    rx_flit = rx_wide_q[FLIT_W-1:0];
    if (!rx_qual_q) begin
      rx_flit[link_pkg::FLIT_VALID_BIT]     = 1'b0;
      rx_flit[link_pkg::FLIT_CRC_VALID_BIT] = 1'b0;
      rx_flit[link_pkg::FLIT_DVALID_BIT]    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/ll_sync_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ll_sync_fsm (
  input  logic             clk_wr,
  input  logic             arst_n,
  input  logic             tx_online,
  input  logic             rx_online,
  input  sync_pkg::delay_t delay_x_value,
  input  sync_pkg::delay_t delay_y_value,
  input  sync_pkg::delay_t delay_z_value,
  input  logic             tx_done,
  input  logic             rx_done,
  output logic             tx_load,
  output logic             rx_load,
  output sync_pkg::delay_t tx_load_value,
  output sync_pkg::delay_t rx_load_value,
  output logic             tx_online_delay,
  output logic             tx_training,
  output logic             rx_online_delay
);

  sync_pkg::tx_state_e tx_state;
  sync_pkg::tx_state_e tx_state_nxt;
  sync_pkg::rx_state_e rx_state;
  sync_pkg::rx_state_e rx_state_nxt;

  ////////////////////////////////////////////////////////////
  // Transmit sequencing

  always_comb begin
    tx_state_nxt  = tx_state;
    tx_load       = 1'b0;
    tx_load_value = delay_y_value;
    if (!tx_online) begin
      tx_state_nxt = sync_pkg::TX_OFF;
    end else begin
      case (tx_state)
        sync_pkg::TX_OFF: begin
          // Start the quiet period
          tx_load      = 1'b1;
          tx_state_nxt = sync_pkg::TX_WAIT_Y;
        end
        sync_pkg::TX_WAIT_Y: begin
          if (tx_done) begin
            tx_load       = 1'b1;
            tx_load_value = delay_z_value;
            tx_state_nxt  = sync_pkg::TX_TRAIN;
          end
        end
        sync_pkg::TX_TRAIN: begin
          if (tx_done) begin
            tx_state_nxt = sync_pkg::TX_ON;
          end
        end
        sync_pkg::TX_ON: begin
          tx_state_nxt = sync_pkg::TX_ON;
        end
        default: begin
          tx_state_nxt = sync_pkg::TX_OFF;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive sequencing

  assign rx_load_value = delay_x_value;

  always_comb begin
    rx_state_nxt = rx_state;
    rx_load      = 1'b0;
    if (!rx_online) begin
      rx_state_nxt = sync_pkg::RX_OFF;
    end else begin
      case (rx_state)
        sync_pkg::RX_OFF: begin
          rx_load      = 1'b1;
          rx_state_nxt = sync_pkg::RX_WAIT_X;
        end
        sync_pkg::RX_WAIT_X: begin
          if (rx_done) begin
            rx_state_nxt = sync_pkg::RX_ON;
          end
        end
        default: begin
          rx_state_nxt = sync_pkg::RX_ON;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= sync_pkg::TX_OFF;
      rx_state <= sync_pkg::RX_OFF;
    end else begin
      tx_state <= tx_state_nxt;
      rx_state <= rx_state_nxt;
    end
  end

  assign tx_online_delay = (tx_state == sync_pkg::TX_ON);
  assign tx_training     = (tx_state == sync_pkg::TX_TRAIN);
  assign rx_online_delay = (rx_state == sync_pkg::RX_ON);

endmodule

`default_nettype wire

// File: logic/ll_txrx_top.sv
`timescale 1ns/1ps
`default_nettype none

module ll_txrx_top #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk_wr,
  input  logic                 arst_n,
  input  logic                 tx_online,
  input  logic                 rx_online,

  // PHY lanes
  output link_pkg::lane_t      tx_phy0,
  input  link_pkg::lane_t      rx_phy0,
  output link_pkg::lane_t      tx_phy1,
  input  link_pkg::lane_t      rx_phy1,
  output link_pkg::lane_t      tx_phy2,
  input  link_pkg::lane_t      rx_phy2,
  output link_pkg::lane_t      tx_phy3,
  input  link_pkg::lane_t      rx_phy3,

  // Downstream fields
  input  link_pkg::state_t     dstrm_state,
  input  link_pkg::protid_t    dstrm_protid,
  input  link_pkg::payload_t   dstrm_data,
  input  logic                 dstrm_dvalid,
  input  link_pkg::crc_t       dstrm_crc,
  input  logic                 dstrm_crc_valid,
  input  logic                 dstrm_valid,

  // Upstream fields
  output link_pkg::state_t     ustrm_state,
  output link_pkg::protid_t    ustrm_protid,
  output link_pkg::payload_t   ustrm_data,
  output logic                 ustrm_dvalid,
  output link_pkg::crc_t       ustrm_crc,
  output logic                 ustrm_crc_valid,
  output logic                 ustrm_valid,

  output link_pkg::debug_cnt_t tx_downstream_debug_status,
  output link_pkg::debug_cnt_t rx_upstream_debug_status,

  input  sync_pkg::delay_t     delay_x_value,
  input  sync_pkg::delay_t     delay_y_value,
  input  sync_pkg::delay_t     delay_z_value
);

  logic             tx_load;
  logic             rx_load;
  logic             tx_done;
  logic             rx_done;
  sync_pkg::delay_t tx_load_value;
  sync_pkg::delay_t rx_load_value;
  logic             tx_online_delay;
  logic             tx_training;
  logic             rx_online_delay;
  link_pkg::flit_t  tx_flit;
  link_pkg::flit_t  rx_flit;
  link_pkg::lane_t  tx_lane [NUM_LANES];
  link_pkg::lane_t  rx_lane [NUM_LANES];

  ////////////////////////////////////////////////////////////
  // Online sequencing

  ll_sync_fsm u_sync_fsm (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_done         (tx_done),
    .rx_done         (rx_done),
    .tx_load         (tx_load),
    .rx_load         (rx_load),
    .tx_load_value   (tx_load_value),
    .rx_load_value   (rx_load_value),
    .tx_online_delay (tx_online_delay),
    .tx_training     (tx_training),
    .rx_online_delay (rx_online_delay)
  );

  ll_delay_timer tx_timer (
    .clk_wr     (clk_wr),
    .arst_n     (arst_n),
    .load       (tx_load),
    .load_value (tx_load_value),
    .done       (tx_done)
  );

  ll_delay_timer rx_timer (
    .clk_wr     (clk_wr),
    .arst_n     (arst_n),
    .load       (rx_load),
    .load_value (rx_load_value),
    .done       (rx_done)
  );

  ////////////////////////////////////////////////////////////
  // Flit and lane path

  ll_flit_map u_flit_map (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  ll_lane_concat #(
    .NUM_LANES (NUM_LANES)
  ) u_lane_concat (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_flit         (tx_flit),
    .dstrm_valid     (dstrm_valid),
    .tx_online_delay (tx_online_delay),
    .tx_training     (tx_training),
    .rx_online_delay (rx_online_delay),
    .tx_lane         (tx_lane),
    .rx_lane         (rx_lane),
    .rx_flit         (rx_flit),
    .tx_count        (tx_downstream_debug_status),
    .rx_count        (rx_upstream_debug_status)
  );

  // Numbered PHY ports
  assign tx_phy0    = tx_lane[0];
  assign tx_phy1    = tx_lane[1];
  assign tx_phy2    = tx_lane[2];
  assign tx_phy3    = tx_lane[3];
  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

endmodule

`default_nettype wire

// File: logic/sync_pkg.sv
`default_nettype none

package sync_pkg;

  // Delay programmed in clock cycles
  typedef logic [15:0] delay_t;

  // Transmit side goes through training before data
  typedef enum logic [1:0] {
    TX_OFF,
    TX_WAIT_Y,
    TX_TRAIN,
    TX_ON
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_OFF,
    RX_WAIT_X,
    RX_ON
  } rx_state_e;

endpackage

`default_nettype wire

// File: verilog.f
logic/link_pkg.sv
logic/sync_pkg.sv
logic/ll_delay_timer.sv
logic/ll_sync_fsm.sv
logic/ll_flit_map.sv
logic/ll_lane_concat.sv
logic/ll_txrx_top.sv
dv/tb_clk_gen.sv
dv/ll_txrx_assertions.sv
dv/tb_ll_txrx.sv
